// ==== common/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define INSTR_W     16
`define REG_SEL_W   4

// opcode field, bits 7..3
`define OP_JMP      5'b10110
`define OP_CALL     5'b10111
`define OP_RET      5'b11000
`define OP_HLT      5'b11101
`define OP_RR_LO    5'b00001
`define OP_RR_HI    5'b01100

// sub-operation field, bits 2..0
`define SUB_NONE    3'b000
`define SUB_IN      3'b010
`define SUB_OUT     3'b100
`define IMM_OP_MAX  3'b111      // aluOp 111 is not an R-I op

`define ALU_PASS_B  4'b0000
`define ALU_PASS_A  4'b1101

`define IMEM_PC_PLUS_ONE 3'b000
`define IMEM_PC_OUT      3'b001
`define IMEM_FETCHED     3'b011

`define DMEM_PC_MSB 2'b00
`define DMEM_PC_LSB 2'b01
`define DMEM_ALU    2'b10

`define SP_LOW_REG  4'b1110

`define RF_SRC_ALU   2'b00
`define SRCA_REG     1'b1
`define SRCA_STATUS  1'b0       // zero-extended status register
`define SRCB_REG     2'b00
`define SRCB_IMM     2'b10
`define DADDR_PAIR   1'b0       // {regFileOutC, regFileOutB}
`define DADDR_DIRECT 1'b1       // 8-bit address from the word

`endif

// ==== common/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    `include "cpu_settings.svh"

    // R-I format: ALU op with an 8-bit immediate
    typedef struct packed {
        logic [`REG_SEL_W-1:0] dstReg;
        logic [7:0]            imm;
        logic [2:0]            aluOp;
        logic                  immFlag;     // bit 0
    } immView_t;

    // every other format
    typedef struct packed {
        logic [2:0]            cond;        // shares bits 15..13 with dstReg
        logic                  dstLow;
        logic [`REG_SEL_W-1:0] srcReg;
        logic [4:0]            opcode;
        logic [2:0]            subOp;
    } regView_t;

    // the same instruction word read two ways
    typedef union packed {
        immView_t immView;
        regView_t regView;
    } instrWord_u;

    // nine classes need a 4-bit code
    typedef enum logic [3:0] {
        nop,
        aluImm,
        aluReg,
        in,
        out,
        jmp,
        call,
        ret,
        hlt
    } instrClass_e;

    typedef struct packed {
        instrClass_e           instrClass;
        logic [3:0]            aluMode;
        logic [`REG_SEL_W-1:0] regBSelect;
        logic [2:0]            cond;
    } decodedInstr_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic [1:0]            regFileSrc;
        logic [`REG_SEL_W-1:0] regFileOutBSelect;
        logic                  regFileWriteEnable;
        logic                  regFileIncPair;      // stack pointer up
        logic                  regFileDecPair;      // stack pointer down
        logic                  aluSrcASelect;
        logic [1:0]            aluSrcBSelect;
        logic [3:0]            aluMode;
        logic [1:0]            dMemDataSelect;
        logic                  dMemAddressSelect;
        logic                  dMemWriteEn;
        logic                  dMemReadEn;
        logic                  flagEnable;
        logic [2:0]            iMemAddrSelect;
        logic                  iMemReadEnable;
        logic                  pcWriteEn;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== decode/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module instrDecoder (
    input  wire ctrlPkg::instrWord_u instr,
    output ctrlPkg::decodedInstr_t   decoded
);

    import ctrlPkg::*;

    immView_t    immView;
    regView_t    regView;
    instrClass_e instrClass;
    logic        isImm;
    logic        isPlain;      // no sub-operation bits set
    logic        inRrRange;

    assign immView = instr.immView;
    assign regView = instr.regView;

    assign isImm     = immView.immFlag && (immView.aluOp < `IMM_OP_MAX);
    assign isPlain   = (regView.subOp == `SUB_NONE);
    assign inRrRange = (regView.opcode >= `OP_RR_LO) && (regView.opcode <= `OP_RR_HI);

    // classification, R-I wins over everything else
    always_comb begin
        if (isImm) begin
            instrClass = aluImm;
        end else if (regView.subOp == `SUB_IN) begin
            instrClass = in;
        end else if (regView.subOp == `SUB_OUT) begin
            instrClass = out;
        end else if (isPlain && inRrRange) begin
            instrClass = aluReg;
        end else if (isPlain) begin
            case (regView.opcode)
                `OP_JMP:  instrClass = jmp;
                `OP_CALL: instrClass = call;
                `OP_RET:  instrClass = ret;
                `OP_HLT:  instrClass = hlt;
                default:  instrClass = nop;     // unused codes
            endcase
        end else begin
            instrClass = nop;
        end
    end

    assign decoded.instrClass = instrClass;

    // ALU mode per class
    always_comb begin
        case (instrClass)
            aluImm:  decoded.aluMode = {1'b0, immView.aluOp};
            aluReg:  decoded.aluMode = regView.opcode[3:0];    // bits 6..3
            jmp:     decoded.aluMode = `ALU_PASS_A;
            default: decoded.aluMode = `ALU_PASS_B;             // in, out and the rest
        endcase
    end

    // register file port B
    always_comb begin
        case (instrClass)
            aluReg:    decoded.regBSelect = regView.srcReg;
            call, ret: decoded.regBSelect = `SP_LOW_REG;
            default:   decoded.regBSelect = immView.dstReg;
        endcase
    end

    // tested later against the stored flags
    assign decoded.cond = regView.cond;

endmodule

`default_nettype wire

// ==== logic/statusFlags.sv ====
`timescale 1ns/1ns
`default_nettype none

module statusFlags (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire ctrlPkg::flags_t aluFlags,
    input  wire                  flagEnable,
    input  wire [2:0]            cond,
    output logic                 condition
);

    import ctrlPkg::*;

    flags_t storedFlags;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            storedFlags <= '0;
        end else if (flagEnable) begin
            storedFlags <= aluFlags;    // visible to the next instruction
        end
    end

    always_comb begin
        case (cond)
            3'b000:  condition = 1'b1;                  // always
            3'b001:  condition = storedFlags.carry;
            3'b010:  condition = ~storedFlags.carry;
            3'b011:  condition = storedFlags.zero;
            3'b100:  condition = ~storedFlags.zero;
            3'b101:  condition = storedFlags.negative;
            3'b111:  condition = ~storedFlags.negative;
            default: condition = 1'b0;                  // 110, never
        endcase
    end

endmodule

`default_nettype wire

// ==== sequence/controlSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module controlSequencer (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire ctrlPkg::decodedInstr_t decoded,
    input  wire                         condition,
    output ctrlPkg::ctrlWord_t          ctrl
);

    import ctrlPkg::*;

    typedef enum logic {
        phaseFirst,
        phaseSecond
    } phase_e;

    phase_e phase;
    phase_e nextPhase;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= phaseFirst;
        end else begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        // NOP word, every class starts from here
        ctrl.regFileSrc         = `RF_SRC_ALU;
        ctrl.regFileOutBSelect  = decoded.regBSelect;
        ctrl.regFileWriteEnable = 1'b0;
        ctrl.regFileIncPair     = 1'b0;
        ctrl.regFileDecPair     = 1'b0;
        ctrl.aluSrcASelect      = `SRCA_REG;
        ctrl.aluSrcBSelect      = `SRCB_REG;
        ctrl.aluMode            = decoded.aluMode;
        ctrl.dMemDataSelect     = `DMEM_ALU;
        ctrl.dMemAddressSelect  = `DADDR_PAIR;
        ctrl.dMemWriteEn        = 1'b0;
        ctrl.dMemReadEn         = 1'b0;
        ctrl.flagEnable         = 1'b0;
        ctrl.iMemAddrSelect     = `IMEM_PC_OUT;
        ctrl.iMemReadEnable     = 1'b1;
        ctrl.pcWriteEn          = 1'b1;
        nextPhase               = phaseFirst;

        case (decoded.instrClass)
            aluImm, aluReg: begin
                ctrl.regFileWriteEnable = 1'b1;
                ctrl.flagEnable         = 1'b1;
                if (decoded.instrClass == aluImm) begin
                    ctrl.aluSrcBSelect = `SRCB_IMM;
                end
            end
            in: begin
                ctrl.dMemAddressSelect = `DADDR_DIRECT;
                ctrl.dMemReadEn        = 1'b1;
                if (phase == phaseFirst) begin
                    ctrl.iMemReadEnable = 1'b0;     // wait for the memory read
                    ctrl.pcWriteEn      = 1'b0;
                    nextPhase           = phaseSecond;
                end else begin
                    ctrl.regFileWriteEnable = 1'b1;
                end
            end
            out: begin
                ctrl.dMemAddressSelect = `DADDR_DIRECT;
                ctrl.dMemWriteEn       = 1'b1;
            end
            jmp: begin
                ctrl.aluSrcASelect = `SRCA_STATUS;
                if (phase == phaseSecond) begin
                    ctrl.iMemAddrSelect = `IMEM_FETCHED;
                end else if (condition) begin
                    nextPhase = phaseSecond;        // target word is next
                end else begin
                    ctrl.iMemAddrSelect = `IMEM_PC_PLUS_ONE;    // skip the target word
                end
            end
            call: begin
                if (phase == phaseSecond) begin
                    ctrl.dMemDataSelect = `DMEM_PC_MSB;
                    ctrl.dMemWriteEn    = 1'b1;
                    ctrl.regFileDecPair = 1'b1;
                    ctrl.iMemAddrSelect = `IMEM_FETCHED;
                end else begin
                    ctrl.dMemDataSelect = `DMEM_PC_LSB;
                    if (condition) begin
                        ctrl.dMemWriteEn    = 1'b1;     // push low byte first
                        ctrl.regFileDecPair = 1'b1;
                        ctrl.pcWriteEn      = 1'b0;
                        nextPhase           = phaseSecond;
                    end else begin
                        ctrl.iMemAddrSelect = `IMEM_PC_PLUS_ONE;
                    end
                end
            end
            ret: begin
                ctrl.dMemReadEn = 1'b1;             // pop from the stack
                if (phase == phaseSecond) begin
                    ctrl.regFileIncPair = 1'b1;
                    ctrl.iMemAddrSelect = `IMEM_FETCHED;
                end else if (condition) begin
                    ctrl.regFileIncPair = 1'b1;
                    ctrl.iMemAddrSelect = `IMEM_FETCHED;
                    ctrl.iMemReadEnable = 1'b0;
                    ctrl.pcWriteEn      = 1'b0;
                    nextPhase           = phaseSecond;
                end
            end
            hlt: begin
                ctrl.iMemReadEnable = 1'b0;
                ctrl.pcWriteEn      = 1'b0;     // PC frozen while the word stays
            end
            default: begin
                nextPhase = phaseFirst;         // nop keeps the default word
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire ctrlPkg::instrWord_u instr,
    input  wire ctrlPkg::flags_t     aluFlags,
    output ctrlPkg::ctrlWord_t       ctrl
);

    import ctrlPkg::*;

    decodedInstr_t decoded;
    logic          condition;

    instrDecoder decoder_i (
        .instr   (instr),
        .decoded (decoded)
    );

    // flags load on the flagEnable of the current control word
    statusFlags flags_i (
        .clk        (clk),
        .rstN       (rstN),
        .aluFlags   (aluFlags),
        .flagEnable (ctrl.flagEnable),
        .cond       (decoded.cond),
        .condition  (condition)
    );

    controlSequencer sequencer_i (
        .clk       (clk),
        .rstN      (rstN),
        .decoded   (decoded),
        .condition (condition),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/controlUnit_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module controlUnit_properties (
    input wire                      clk,
    input wire                      rstN,
    input wire ctrlPkg::instrWord_u instr,
    input wire ctrlPkg::flags_t     aluFlags,
    input wire ctrlPkg::ctrlWord_t  ctrl
);

    import ctrlPkg::*;

    logic   isImm, plain, isRr, isIn, isOut, isJmp, isCall, isRet, isHlt;
    logic   second;         // expected phase, set while in the second phase
    logic   condOk;
    flags_t seenFlags;      // flags latched by earlier ALU words
    logic   failSeen = 1'b0;
    string  failName;
    logic [15:0] failGot, failExp;
    time    failTime;

    assign isImm  = instr.immView.immFlag && (instr.immView.aluOp != 3'b111);
    assign plain  = !isImm && (instr.regView.subOp == `SUB_NONE);
    assign isRr   = plain && (instr.regView.opcode >= `OP_RR_LO)
                    && (instr.regView.opcode <= `OP_RR_HI);
    assign isIn   = !isImm && (instr.regView.subOp == `SUB_IN);
    assign isOut  = !isImm && (instr.regView.subOp == `SUB_OUT);
    assign isJmp  = plain && (instr.regView.opcode == `OP_JMP);
    assign isCall = plain && (instr.regView.opcode == `OP_CALL);
    assign isRet  = plain && (instr.regView.opcode == `OP_RET);
    assign isHlt  = plain && (instr.regView.opcode == `OP_HLT);

    always_comb begin
        case (instr.regView.cond)
            3'b000:  condOk = 1'b1;
            3'b001:  condOk = seenFlags.carry;
            3'b010:  condOk = !seenFlags.carry;
            3'b011:  condOk = seenFlags.zero;
            3'b100:  condOk = !seenFlags.zero;
            3'b101:  condOk = seenFlags.negative;
            3'b111:  condOk = !seenFlags.negative;
            default: condOk = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            seenFlags <= '0;
            second    <= 1'b0;
        end else begin
            if (isImm || isRr) begin
                seenFlags <= aluFlags;
            end
            second <= !second && (isIn || ((isJmp || isCall || isRet) && condOk));
        end
    end

    task automatic noteFail(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (!failSeen) begin
            failSeen = 1'b1;
            failName = name;
            failGot  = got;
            failExp  = exp;
            failTime = $time;
        end
        $error("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    aImmMode: assert property (@(posedge clk) disable iff (!rstN)
        isImm |-> ctrl.aluMode == {1'b0, instr.immView.aluOp})
        else noteFail("ctrl.aluMode", 16'(ctrl.aluMode), 16'({1'b0, instr.immView.aluOp}));

    aImmCtl: assert property (@(posedge clk) disable iff (!rstN)
        isImm |-> {ctrl.regFileWriteEnable, ctrl.flagEnable, ctrl.pcWriteEn,
                   ctrl.aluSrcBSelect} == {3'b111, `SRCB_IMM})
        else noteFail("{regFileWriteEnable,flagEnable,pcWriteEn,aluSrcBSelect}",
                      16'({ctrl.regFileWriteEnable, ctrl.flagEnable, ctrl.pcWriteEn,
                           ctrl.aluSrcBSelect}), 16'({3'b111, `SRCB_IMM}));

    // ALU mode is taken straight from word bits 6..3
    aRr: assert property (@(posedge clk) disable iff (!rstN)
        isRr |-> {ctrl.aluMode, ctrl.regFileOutBSelect}
                 == {instr[6:3], instr.regView.srcReg})
        else noteFail("{aluMode,regFileOutBSelect}",
                      16'({ctrl.aluMode, ctrl.regFileOutBSelect}),
                      16'({instr[6:3], instr.regView.srcReg}));

    aInFirst: assert property (@(posedge clk) disable iff (!rstN)
        isIn && !second |-> {ctrl.pcWriteEn, ctrl.regFileWriteEnable, ctrl.iMemReadEnable,
                             ctrl.dMemReadEn} == 4'b0001)
        else noteFail("{pcWriteEn,regFileWriteEnable,iMemReadEnable,dMemReadEn}",
                      16'({ctrl.pcWriteEn, ctrl.regFileWriteEnable, ctrl.iMemReadEnable,
                           ctrl.dMemReadEn}), 16'h1);

    aInSecond: assert property (@(posedge clk) disable iff (!rstN)
        isIn && second |-> {ctrl.pcWriteEn, ctrl.regFileWriteEnable, ctrl.iMemReadEnable}
                           == 3'b111)
        else noteFail("{pcWriteEn,regFileWriteEnable,iMemReadEnable}",
                      16'({ctrl.pcWriteEn, ctrl.regFileWriteEnable, ctrl.iMemReadEnable}),
                      16'h7);

    aOut: assert property (@(posedge clk) disable iff (!rstN)
        isOut |-> {ctrl.dMemWriteEn, ctrl.dMemReadEn, ctrl.dMemAddressSelect, ctrl.pcWriteEn}
                  == {2'b10, `DADDR_DIRECT, 1'b1})
        else noteFail("{dMemWriteEn,dMemReadEn,dMemAddressSelect,pcWriteEn}",
                      16'({ctrl.dMemWriteEn, ctrl.dMemReadEn, ctrl.dMemAddressSelect,
                           ctrl.pcWriteEn}), 16'({2'b10, `DADDR_DIRECT, 1'b1}));

    aCallFirst: assert property (@(posedge clk) disable iff (!rstN)
        isCall && !second && condOk |-> {ctrl.dMemWriteEn, ctrl.regFileDecPair,
                                         ctrl.dMemDataSelect} == {2'b11, `DMEM_PC_LSB})
        else noteFail("{dMemWriteEn,regFileDecPair,dMemDataSelect}",
                      16'({ctrl.dMemWriteEn, ctrl.regFileDecPair, ctrl.dMemDataSelect}),
                      16'({2'b11, `DMEM_PC_LSB}));

    aCallSecond: assert property (@(posedge clk) disable iff (!rstN)
        isCall && second |-> {ctrl.dMemWriteEn, ctrl.regFileDecPair, ctrl.dMemDataSelect,
                              ctrl.iMemAddrSelect, ctrl.pcWriteEn}
                             == {2'b11, `DMEM_PC_MSB, `IMEM_FETCHED, 1'b1})
        else noteFail("{dMemWriteEn,regFileDecPair,dMemDataSelect,iMemAddrSelect,pcWriteEn}",
                      16'({ctrl.dMemWriteEn, ctrl.regFileDecPair, ctrl.dMemDataSelect,
                           ctrl.iMemAddrSelect, ctrl.pcWriteEn}),
                      16'({2'b11, `DMEM_PC_MSB, `IMEM_FETCHED, 1'b1}));

    aCallSkip: assert property (@(posedge clk) disable iff (!rstN)
        isCall && !second && !condOk |-> {ctrl.pcWriteEn, ctrl.iMemAddrSelect}
                                         == {1'b1, `IMEM_PC_PLUS_ONE})
        else noteFail("{pcWriteEn,iMemAddrSelect}", 16'({ctrl.pcWriteEn, ctrl.iMemAddrSelect}),
                      16'({1'b1, `IMEM_PC_PLUS_ONE}));

    aJmpFirst: assert property (@(posedge clk) disable iff (!rstN)
        isJmp && !second && condOk |-> {ctrl.pcWriteEn, ctrl.iMemAddrSelect}
                                       == {1'b1, `IMEM_PC_OUT})
        else noteFail("{pcWriteEn,iMemAddrSelect}", 16'({ctrl.pcWriteEn, ctrl.iMemAddrSelect}),
                      16'({1'b1, `IMEM_PC_OUT}));

    aJmpSecond: assert property (@(posedge clk) disable iff (!rstN)
        isJmp && second |-> {ctrl.pcWriteEn, ctrl.iMemAddrSelect} == {1'b1, `IMEM_FETCHED})
        else noteFail("{pcWriteEn,iMemAddrSelect}", 16'({ctrl.pcWriteEn, ctrl.iMemAddrSelect}),
                      16'({1'b1, `IMEM_FETCHED}));

    aRetFirst: assert property (@(posedge clk) disable iff (!rstN)
        isRet && !second && condOk |-> {ctrl.pcWriteEn, ctrl.regFileIncPair} == 2'b01)
        else noteFail("{pcWriteEn,regFileIncPair}",
                      16'({ctrl.pcWriteEn, ctrl.regFileIncPair}), 16'h1);

    aRetDone: assert property (@(posedge clk) disable iff (!rstN)
        isRet && (second || !condOk) |-> ctrl.pcWriteEn)
        else noteFail("pcWriteEn", 16'(ctrl.pcWriteEn), 16'h1);

    aHlt: assert property (@(posedge clk) disable iff (!rstN)
        isHlt |-> {ctrl.pcWriteEn, ctrl.iMemReadEnable} == 2'b00)
        else noteFail("{pcWriteEn,iMemReadEnable}",
                      16'({ctrl.pcWriteEn, ctrl.iMemReadEnable}), 16'h0);

endmodule

bind controlUnit controlUnit_properties props_i (.*);

`default_nettype wire

// ==== sim/controlUnit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module controlUnit_tb;

    import ctrlPkg::*;

    localparam int randomRuns = 300;
    localparam int maxCycles  = 10 + 20 + randomRuns * 4;

    logic       clk;
    logic       rstN;
    instrWord_u instr;
    flags_t     aluFlags;
    ctrlWord_t  ctrl;
    integer     seed = 73;

    clockGen clockGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    controlUnit dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .aluFlags (aluFlags),
        .ctrl     (ctrl)
    );

    function automatic instrWord_u immWord(input logic [3:0] dst, input logic [7:0] imm,
                                           input logic [2:0] op);
        immWord = {dst, imm, op, 1'b1};
    endfunction

    function automatic instrWord_u regWord(input logic [2:0] cond, input logic [3:0] src,
                                           input logic [4:0] opcode, input logic [2:0] sub);
        regWord = {cond, 1'b0, src, opcode, sub};
    endfunction

    // word changes on a rising edge and stays for n cycles
    task automatic apply(input instrWord_u w, input flags_t f, input int n);
        @(posedge clk);
        instr    <= w;
        aluFlags <= f;
        repeat (n - 1) @(posedge clk);
    endtask

    task automatic reportFailure();
        $display("Fail at %0t: %s got %h expected %h", dut_i.props_i.failTime,
                 dut_i.props_i.failName, dut_i.props_i.failGot, dut_i.props_i.failExp);
        $display("Simulation FAILED");
        $fatal(1, "a control check failed");
    endtask

    always @(negedge clk) begin
        if (dut_i.props_i.failSeen) begin
            reportFailure();
        end
    end

    initial begin
        #(maxCycles * 8 + 400);
        $display("The run timed out before the stimulus finished");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        logic [2:0]  op;
        logic [4:0]  opc;

        instr    = regWord(3'b000, 4'h3, 5'b00000, `SUB_IN);    // IN across reset release
        aluFlags = '0;
        wait (rstN);
        @(posedge clk);

        // zero flag set, then conditional flow
        apply(immWord(4'h1, 8'h10, 3'b010), 3'b010, 1);
        apply(regWord(3'b011, 4'h2, `OP_CALL, `SUB_NONE), 3'b000, 2);
        apply(regWord(3'b110, 4'h2, `OP_CALL, `SUB_NONE), 3'b000, 1);
        apply(regWord(3'b000, 4'h0, `OP_JMP, `SUB_NONE), 3'b000, 2);
        apply(regWord(3'b000, 4'h0, `OP_RET, `SUB_NONE), 3'b000, 2);
        apply(regWord(3'b110, 4'h0, `OP_RET, `SUB_NONE), 3'b000, 1);
        apply(regWord(3'b000, 4'h4, 5'b00000, `SUB_OUT), 3'b000, 1);
        apply(regWord(3'b000, 4'h7, 5'b00101, `SUB_NONE), 3'b100, 1);
        apply(regWord(3'b000, 4'h0, `OP_HLT, `SUB_NONE), 3'b000, 3);

        for (int i = 0; i < randomRuns; i++) begin
            r   = $random(seed);
            op  = (r[18:16] == 3'b111) ? 3'b000 : r[18:16];
            opc = {1'b0, r[19:16]};
            if (opc == 5'b00000 || opc > `OP_RR_HI) begin
                opc = `OP_RR_LO;
            end
            case (r[2:0])
                3'd0: apply(immWord(r[7:4], r[15:8], op), r[31:29], 1);
                3'd1: apply(regWord(r[22:20], r[7:4], opc, `SUB_NONE), r[31:29], 1);
                3'd2: apply(regWord(r[22:20], r[7:4], r[27:23], `SUB_IN), r[31:29], 2);
                3'd3: apply(regWord(r[22:20], r[7:4], r[27:23], `SUB_OUT), r[31:29], 1);
                3'd4: apply(regWord(r[22:20], r[7:4], `OP_JMP, `SUB_NONE), r[31:29], 2);
                3'd5: apply(regWord(r[22:20], r[7:4], `OP_CALL, `SUB_NONE), r[31:29], 2);
                3'd6: apply(regWord(r[22:20], r[7:4], `OP_RET, `SUB_NONE), r[31:29], 2);
                default: apply(regWord(r[22:20], r[7:4], `OP_HLT, `SUB_NONE), r[31:29],
                               1 + int'(r[9:8]));
            endcase
        end

        @(posedge clk);     // last cycle of the final word
        @(negedge clk);
        if (dut_i.props_i.failSeen) begin
            reportFailure();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/ctrlPkg.sv
decode/instrDecoder.sv
logic/statusFlags.sv
sequence/controlSequencer.sv
logic/controlUnit.sv
sim/clockGen.sv
sim/controlUnit_properties.sv
sim/controlUnit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --assert --timing -j 0
TOP       := controlUnit_tb
FILELIST  := src.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/cpu_settings.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
